// ==== lockSystem.f ====
+incdir+include
rtl/lockPkg.sv
rtl/lockChamber.sv
rtl/gondolaSequencer.sv
rtl/lockSystem.sv
tb/lockSystemTb.sv

// ==== include/lockTbTasks.svh ====
`ifndef LOCK_TB_TASKS_SVH
`define LOCK_TB_TASKS_SVH

// Xorshift step for the random level bursts
function automatic logic [31:0] xorshift(input logic [31:0] state);
	logic [31:0] x;
	x = state;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

task automatic waitCycles(input int count);
	repeat (count) @(negedge clk);
endtask

task automatic raiseToOuter();
	raiseReq = 1'b1;
	while (lockWater != lockPkg::DEFAULT_OUTER_LEVEL) @(negedge clk);
	raiseReq = 1'b0;
endtask

task automatic lowerToInner();
	lowerReq = 1'b1;
	while (lockWater != lockPkg::DEFAULT_INNER_LEVEL) @(negedge clk);
	lowerReq = 1'b0;
endtask

// Gate request 1 closes, 0 opens; waits until the status follows
task automatic moveOuterGate(input logic close);
	outerGateReq = close;
	while (outerGateClosed != close) @(negedge clk);
endtask

task automatic moveInnerGate(input logic close);
	innerGateReq = close;
	while (innerGateClosed != close) @(negedge clk);
endtask

task automatic reportMismatch(input string name, input int expected, input int actual);
	failCount++;
	$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
endtask

task automatic reportRule(input string what);
	failCount++;
	$display("Rule broken in %s: %s", testName, what);
endtask

task automatic startTest(input string name);
	testName = name;
	failsAtStart = failCount;
endtask

task automatic finishTest();
	testsRun++;
	if (failCount == failsAtStart) begin
		$display("PASS %s", testName);
	end else begin
		testsFailed++;
		$display("FAIL %s (%0d errors)", testName, failCount - failsAtStart);
	end
endtask

`endif

// ==== tb/lockSystemTb.sv ====
module lockSystemTb;

	localparam int OUTER = lockPkg::DEFAULT_OUTER_LEVEL;
	localparam int INNER = lockPkg::DEFAULT_INNER_LEVEL;
	localparam int RAISE = lockPkg::DEFAULT_RAISE_STEP;
	localparam int LOWER = lockPkg::DEFAULT_LOWER_STEP;
	localparam int DELAY = lockPkg::DEFAULT_ARRIVAL_DELAY;
	// Rough cycle budget of each test, plus margin
	localparam int CYCLE_LIMIT = 10 + 300 + 80 + 40 + 80 + 100 + 150;

	logic clk;
	logic rst;
	logic arriveReq;
	logic departReq;
	lockPkg::sideT entrySide;
	logic raiseReq;
	logic lowerReq;
	logic outerGateReq;
	logic innerGateReq;
	lockPkg::levelT lockWater;
	logic outerGateClosed;
	logic innerGateClosed;
	logic gondolaArriving;
	logic gondolaDeparting;
	logic gondolaInside;

	string testName = "reset";
	int failCount = 0;
	int failsAtStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int cycleCount = 0;
	int modelWater; // Expected level from the lock rules
	logic modelOuter;
	logic modelInner;
	lockPkg::sideT tbSide; // Side the gondola under test came in through
	logic exitOpen;

	lockSystem DUT (
		.clk(clk),
		.rst(rst),
		.arriveReq(arriveReq),
		.departReq(departReq),
		.entrySide(entrySide),
		.raiseReq(raiseReq),
		.lowerReq(lowerReq),
		.outerGateReq(outerGateReq),
		.innerGateReq(innerGateReq),
		.lockWater(lockWater),
		.outerGateClosed(outerGateClosed),
		.innerGateClosed(innerGateClosed),
		.gondolaArriving(gondolaArriving),
		.gondolaDeparting(gondolaDeparting),
		.gondolaInside(gondolaInside)
	);

	`include "lockTbTasks.svh"

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Level and gate model: saturate at basins, move only sealed
	always @(posedge clk) begin
		if (rst) begin
			modelWater <= lockPkg::DEFAULT_RESET_LEVEL;
			modelOuter <= 1'b1;
			modelInner <= 1'b1;
		end else begin
			if (modelOuter && modelInner) begin
				if (raiseReq) begin
					modelWater <= (modelWater + RAISE > OUTER) ? OUTER : modelWater + RAISE;
				end else if (lowerReq) begin
					modelWater <= (modelWater - LOWER < INNER) ? INNER : modelWater - LOWER;
				end
			end
			if (modelWater == OUTER) modelOuter <= outerGateReq;
			if (modelWater == INNER) modelInner <= innerGateReq;
		end
	end

	assign exitOpen = (tbSide == lockPkg::SIDE_OUTER) ? !innerGateClosed : !outerGateClosed;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles in %s", cycleCount, testName);
			$display("Some tests failed");
			$finish;
		end
	end

	resetState: assert property (@(posedge clk)
		$fell(rst) |-> (lockWater == lockPkg::DEFAULT_RESET_LEVEL) && outerGateClosed &&
			innerGateClosed && !gondolaArriving && !gondolaDeparting && !gondolaInside
	) else reportRule("outputs not in reset state after reset");

	waterMatches: assert property (@(posedge clk) disable iff (rst)
		int'(lockWater) == modelWater
	) else reportMismatch(testName, $sampled(modelWater), $sampled(lockWater));

	outerMatches: assert property (@(posedge clk) disable iff (rst)
		outerGateClosed == modelOuter
	) else reportMismatch(testName, $sampled(modelOuter), $sampled(outerGateClosed));

	innerMatches: assert property (@(posedge clk) disable iff (rst)
		innerGateClosed == modelInner
	) else reportMismatch(testName, $sampled(modelInner), $sampled(innerGateClosed));

	outerOpensAtBasin: assert property (@(posedge clk) disable iff (rst)
		$fell(outerGateClosed) |-> $past(lockWater) == OUTER
	) else reportRule("outer gate opened away from the outer level");

	innerOpensAtBasin: assert property (@(posedge clk) disable iff (rst)
		$fell(innerGateClosed) |-> $past(lockWater) == INNER
	) else reportRule("inner gate opened away from the inner level");

	// Settle delay plus one entry cycle, seen at the next sample
	entryTiming: assert property (@(posedge clk) disable iff (rst)
		gondolaArriving && !gondolaInside &&
			((entrySide == lockPkg::SIDE_OUTER) ? !outerGateClosed : !innerGateClosed)
			|-> ##(DELAY + 2) $rose(gondolaInside)
	) else reportRule("gondola did not enter on time");

	noSecondArrival: assert property (@(posedge clk) disable iff (rst)
		gondolaArriving |=> !gondolaArriving [*(DELAY + 1)]
	) else reportRule("second arrival accepted while one was pending");

	departOnlyOpen: assert property (@(posedge clk) disable iff (rst)
		gondolaDeparting |-> exitOpen ##1 !gondolaInside
	) else reportRule("departure with exit gate closed or gondola stayed inside");

	blockedDeparture: assert property (@(posedge clk) disable iff (rst)
		departReq && gondolaInside && !exitOpen |-> !gondolaDeparting
	) else reportRule("departure granted through a closed gate");

	initial begin
		logic [31:0] rnd;
		int len;
		rst = 1'b1;
		arriveReq = 1'b0;
		departReq = 1'b0;
		entrySide = lockPkg::SIDE_OUTER;
		raiseReq = 1'b0;
		lowerReq = 1'b0;
		outerGateReq = 1'b1;
		innerGateReq = 1'b1;
		tbSide = lockPkg::SIDE_OUTER;
		rnd = 32'h15baef00;
		repeat (3) @(negedge clk);
		rst = 1'b0;

		startTest("resetState");
		waitCycles(2);
		finishTest();

		startTest("saturatingLevel");
		raiseToOuter();
		raiseReq = 1'b1; // Keep pushing at the cap
		waitCycles(5);
		raiseReq = 1'b0;
		lowerToInner();
		lowerReq = 1'b1;
		waitCycles(5);
		lowerReq = 1'b0;
		for (int i = 0; i < 8; i++) begin
			rnd = xorshift(rnd);
			len = int'(rnd[4:1]) + 1;
			raiseReq = rnd[0];
			lowerReq = !rnd[0];
			waitCycles(len);
		end
		raiseReq = 1'b0;
		lowerReq = 1'b0;
		finishTest();

		startTest("gateRule");
		raiseToOuter();
		lowerReq = 1'b1;
		waitCycles(1);
		lowerReq = 1'b0;
		outerGateReq = 1'b0; // Off level, ignored
		innerGateReq = 1'b0;
		waitCycles(4);
		outerGateReq = 1'b1;
		innerGateReq = 1'b1;
		raiseToOuter();
		moveOuterGate(1'b0);
		moveOuterGate(1'b1);
		lowerToInner();
		moveInnerGate(1'b0);
		moveInnerGate(1'b1);
		finishTest();

		startTest("waterLocked");
		moveInnerGate(1'b0);
		raiseReq = 1'b1; // Would fill if the inner gate were shut
		waitCycles(4);
		raiseReq = 1'b0;
		moveInnerGate(1'b1);
		raiseToOuter();
		moveOuterGate(1'b0);
		lowerReq = 1'b1; // Would drain if the outer gate were shut
		waitCycles(4);
		lowerReq = 1'b0;
		moveOuterGate(1'b1);
		finishTest();

		startTest("fullTransit");
		raiseToOuter();
		moveOuterGate(1'b0);
		entrySide = lockPkg::SIDE_OUTER;
		tbSide = lockPkg::SIDE_OUTER;
		arriveReq = 1'b1;
		waitCycles(1);
		arriveReq = 1'b0;
		while (!gondolaInside) @(negedge clk);
		moveOuterGate(1'b1);
		lowerToInner();
		moveInnerGate(1'b0);
		departReq = 1'b1;
		while (gondolaInside) @(negedge clk);
		departReq = 1'b0;
		finishTest();

		startTest("blockedMoves");
		entrySide = lockPkg::SIDE_INNER;
		arriveReq = 1'b1; // Held through the whole settle window
		waitCycles(DELAY + 2);
		arriveReq = 1'b0;
		tbSide = lockPkg::SIDE_INNER;
		while (!gondolaInside) @(negedge clk);
		moveInnerGate(1'b1);
		departReq = 1'b1; // Outer gate still closed
		waitCycles(4);
		departReq = 1'b0;
		raiseToOuter();
		moveOuterGate(1'b0);
		departReq = 1'b1;
		while (gondolaInside) @(negedge clk);
		departReq = 1'b0;
		moveOuterGate(1'b1);
		finishTest();

		$display("Tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, failCount);
		if (failCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== rtl/lockSystem.sv ====
module lockSystem #(
	parameter lockPkg::levelT OUTER_LEVEL = lockPkg::DEFAULT_OUTER_LEVEL,
	parameter lockPkg::levelT INNER_LEVEL = lockPkg::DEFAULT_INNER_LEVEL,
	parameter lockPkg::levelT RESET_LEVEL = lockPkg::DEFAULT_RESET_LEVEL,
	parameter lockPkg::levelT RAISE_STEP = lockPkg::DEFAULT_RAISE_STEP,
	parameter lockPkg::levelT LOWER_STEP = lockPkg::DEFAULT_LOWER_STEP,
	parameter int ARRIVAL_DELAY = lockPkg::DEFAULT_ARRIVAL_DELAY
) (
	input logic clk,
	input logic rst,

	// Gondola side
	input logic arriveReq,
	input logic departReq,
	input lockPkg::sideT entrySide,

	// Operator controls
	input logic raiseReq,
	input logic lowerReq,
	input logic outerGateReq, // 1 means close
	input logic innerGateReq, // 1 means close

	output lockPkg::levelT lockWater,
	output logic outerGateClosed,
	output logic innerGateClosed,
	output logic gondolaArriving,
	output logic gondolaDeparting,
	output logic gondolaInside
);

	// Gate status shared between chamber and sequencer
	logic outerClosed;
	logic innerClosed;

	assign outerGateClosed = outerClosed;
	assign innerGateClosed = innerClosed;

	lockChamber #(
		.OUTER_LEVEL(OUTER_LEVEL),
		.INNER_LEVEL(INNER_LEVEL),
		.RESET_LEVEL(RESET_LEVEL),
		.RAISE_STEP(RAISE_STEP),
		.LOWER_STEP(LOWER_STEP)
	) chamber (
		.clk(clk),
		.rst(rst),
		.raiseReq(raiseReq),
		.lowerReq(lowerReq),
		.outerGateReq(outerGateReq),
		.innerGateReq(innerGateReq),
		.lockWater(lockWater),
		.outerGateClosed(outerClosed),
		.innerGateClosed(innerClosed)
	);

	gondolaSequencer #(
		.ARRIVAL_DELAY(ARRIVAL_DELAY)
	) sequencer (
		.clk(clk),
		.rst(rst),
		.arriveReq(arriveReq),
		.departReq(departReq),
		.entrySide(entrySide),
		.outerGateClosed(outerClosed),
		.innerGateClosed(innerClosed),
		.gondolaArriving(gondolaArriving),
		.gondolaDeparting(gondolaDeparting),
		.gondolaInside(gondolaInside)
	);

endmodule

// ==== rtl/gondolaSequencer.sv ====
module gondolaSequencer #(
	parameter int ARRIVAL_DELAY = lockPkg::DEFAULT_ARRIVAL_DELAY
) (
	input logic clk,
	input logic rst,
	input logic arriveReq, // Gondola announces itself at a gate
	input logic departReq, // Gondola inside asks to leave
	input lockPkg::sideT entrySide, // Gate the gondola is coming in through
	input logic outerGateClosed,
	input logic innerGateClosed,
	output logic gondolaArriving,
	output logic gondolaDeparting,
	output logic gondolaInside
);

	localparam int TIMER_WIDTH = $clog2(ARRIVAL_DELAY + 1);

	logic [TIMER_WIDTH-1:0] timerCount;
	logic timerIdle;
	logic timerDone;
	logic gondolaWaiting;
	lockPkg::sideT insideSide; // Entry side of the gondola in the chamber
	logic outerOpen;
	logic innerOpen;
	logic entryGateOpen;
	logic exitGateOpen;
	logic admit;

	assign outerOpen = (outerGateClosed != lockPkg::GATE_CLOSED);
	assign innerOpen = (innerGateClosed != lockPkg::GATE_CLOSED);

	assign timerIdle = (timerCount == '0);
	assign timerDone = (timerCount == TIMER_WIDTH'(ARRIVAL_DELAY));

	// Only one gondola may be settling or waiting at a time
	assign gondolaArriving = arriveReq && !gondolaWaiting && timerIdle;

	// Entry uses the live side, exit the side latched on entry
	assign entryGateOpen = (entrySide == lockPkg::SIDE_OUTER) ? outerOpen : innerOpen;
	assign exitGateOpen = (insideSide == lockPkg::SIDE_OUTER) ? innerOpen : outerOpen;

	assign admit = gondolaWaiting && !gondolaInside && entryGateOpen;
	assign gondolaDeparting = gondolaInside && exitGateOpen && departReq;

	// Settling timer runs from 1 up to ARRIVAL_DELAY
	always_ff @(posedge clk) begin
		if (rst) begin
			timerCount <= '0;
		end else if (gondolaArriving) begin
			timerCount <= TIMER_WIDTH'(1);
		end else if (timerDone) begin
			timerCount <= '0;
		end else if (!timerIdle) begin
			timerCount <= timerCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gondolaWaiting <= 1'b0;
		end else if (timerDone) begin
			gondolaWaiting <= 1'b1; // Settled at the gate
		end else if (admit) begin
			gondolaWaiting <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gondolaInside <= 1'b0;
		end else if (admit) begin
			gondolaInside <= 1'b1;
		end else if (gondolaDeparting) begin
			gondolaInside <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (admit) begin
			insideSide <= entrySide;
		end
	end

	// The gate on the latched side was open at the entry edge
	enterThroughOpenGate: assert property (
		@(posedge clk) disable iff (rst)
		$rose(gondolaInside) |->
			((insideSide == lockPkg::SIDE_OUTER) ? $past(outerOpen) : $past(innerOpen))
	) else $error("gondolaSequencer: gondola entered through a closed gate");

	// Leaving needs the opposite gate open and empties the chamber next cycle
	leaveThroughOpenGate: assert property (
		@(posedge clk) disable iff (rst)
		gondolaDeparting |->
			((insideSide == lockPkg::SIDE_OUTER) ? innerOpen : outerOpen) ##1 !gondolaInside
	) else $error("gondolaSequencer: departure without an open exit gate");

endmodule

// ==== rtl/lockChamber.sv ====
module lockChamber #(
	parameter lockPkg::levelT OUTER_LEVEL = lockPkg::DEFAULT_OUTER_LEVEL,
	parameter lockPkg::levelT INNER_LEVEL = lockPkg::DEFAULT_INNER_LEVEL,
	parameter lockPkg::levelT RESET_LEVEL = lockPkg::DEFAULT_RESET_LEVEL,
	parameter lockPkg::levelT RAISE_STEP = lockPkg::DEFAULT_RAISE_STEP,
	parameter lockPkg::levelT LOWER_STEP = lockPkg::DEFAULT_LOWER_STEP
) (
	input logic clk,
	input logic rst,
	input logic raiseReq, // Fill the chamber one step
	input logic lowerReq, // Drain the chamber one step
	input logic outerGateReq, // 1 asks to close the outer gate
	input logic innerGateReq, // 1 asks to close the inner gate
	output lockPkg::levelT lockWater,
	output logic outerGateClosed,
	output logic innerGateClosed
);

	logic waterFree;
	logic atOuter;
	logic atInner;
	lockPkg::levelT outerHeadroom;
	lockPkg::levelT innerHeadroom;
	lockPkg::levelT raisedLevel;
	lockPkg::levelT loweredLevel;

	// Water can only move with the chamber sealed on both ends
	assign waterFree = (outerGateClosed == lockPkg::GATE_CLOSED) &&
		(innerGateClosed == lockPkg::GATE_CLOSED);

	// Level match against each basin
	assign atOuter = (lockWater == OUTER_LEVEL);
	assign atInner = (lockWater == INNER_LEVEL);

	// Distance left before each basin level is reached
	assign outerHeadroom = OUTER_LEVEL - lockWater;
	assign innerHeadroom = lockWater - INNER_LEVEL;

	// Saturate so the basin level is hit exactly instead of overshot
	assign raisedLevel = (outerHeadroom <= RAISE_STEP) ? OUTER_LEVEL :
		lockWater + RAISE_STEP;
	assign loweredLevel = (innerHeadroom <= LOWER_STEP) ? INNER_LEVEL :
		lockWater - LOWER_STEP;

	always_ff @(posedge clk) begin
		if (rst) begin
			lockWater <= RESET_LEVEL;
		end else if (waterFree) begin
			if (raiseReq) begin // Raise has priority
				lockWater <= raisedLevel;
			end else if (lowerReq) begin
				lockWater <= loweredLevel;
			end
		end
	end

	// A gate only moves once the chamber matches its basin
	always_ff @(posedge clk) begin
		if (rst) begin
			outerGateClosed <= lockPkg::GATE_CLOSED;
			innerGateClosed <= lockPkg::GATE_CLOSED;
		end else begin
			if (atOuter) begin
				outerGateClosed <= outerGateReq;
			end
			if (atInner) begin
				innerGateClosed <= innerGateReq;
			end
		end
	end

	// An open gate pins the level for the following cycle
	levelHeldWhileOpen: assert property (
		@(posedge clk) disable iff (rst)
		!waterFree |=> $stable(lockWater)
	) else $error("lockChamber: level moved with a gate open");

	// Reset level and saturation together keep the chamber between the basins
	levelInRange: assert property (
		@(posedge clk) disable iff (rst)
		(lockWater >= INNER_LEVEL) && (lockWater <= OUTER_LEVEL)
	) else $error("lockChamber: level %0d outside basin range", lockWater);

endmodule

// ==== rtl/lockPkg.sv ====
package lockPkg;

	// Width shared by every water level in the design
	localparam int LEVEL_WIDTH = 8;

	typedef logic [LEVEL_WIDTH-1:0] levelT;

	// Basin levels are fixed for a given lock
	localparam levelT DEFAULT_OUTER_LEVEL = levelT'(73); // Outer basin surface
	localparam levelT DEFAULT_INNER_LEVEL = levelT'(49); // Inner basin surface
	localparam levelT DEFAULT_RESET_LEVEL = levelT'(52); // Chamber level out of reset

	// Steps per cycle while the chamber fills or drains
	localparam levelT DEFAULT_RAISE_STEP = levelT'(2);
	localparam levelT DEFAULT_LOWER_STEP = levelT'(1);

	// Cycles a gondola settles at the gate before it counts as waiting
	localparam int DEFAULT_ARRIVAL_DELAY = 10;

	// Gate status encoding
	localparam logic GATE_CLOSED = 1'b1; // Status and request bit value for a shut gate

	// Side a gondola enters the chamber from
	typedef enum logic {
		SIDE_INNER = 1'b0, // Through the inner gate
		SIDE_OUTER = 1'b1 // Through the outer gate
	} sideT;

endpackage
